/* src/exStageMacros.svh */
// Execute stage constants for widths, register IDs and trap codes
`ifndef EX_STAGE_MACROS_SVH
`define EX_STAGE_MACROS_SVH

// Datapath widths
`define EX_XLEN 64
`define EX_ALEN 48

// Register ID widths
`define EX_GR_ID_W 6
`define EX_CR_ID_W 5

// GPR IDs
`define EX_GR_ZZR 6'h3F // No write
`define EX_GR_DLR 6'h00

// Control register IDs
`define EX_CR_ZZR 5'h1F // No write
`define EX_CR_PC 5'h00

// Trap codes whose low bits are filled in by the op
`define EX_TRAP_RTE 16'hFF00
`define EX_TRAP_TRAPA_HI 12'hC08
`define EX_TRAP_SYSE_HI 4'hE

`endif

/* src/exStagePkg.sv */
// Execute stage types for opcodes, sub-ops, conditions and memory requests
`default_nettype none

package exStagePkg;

	typedef enum logic [5:0] {
		UCMD_NOP = 6'h00,
		UCMD_MOV_RM = 6'h01, // Store
		UCMD_MOV_MR = 6'h02, // Load
		UCMD_LEA_MR = 6'h03,
		UCMD_ALU3 = 6'h04,
		UCMD_MUL3 = 6'h05,
		UCMD_MOV_RC = 6'h06,
		UCMD_MOV_CR = 6'h07,
		UCMD_MOV_IR = 6'h08,
		UCMD_BRA = 6'h09,
		UCMD_BSR = 6'h0A,
		UCMD_JMP = 6'h0B,
		UCMD_JSR = 6'h0C,
		UCMD_BRA_NB = 6'h0D, // Branch not taken
		UCMD_OP_IXS = 6'h0E,
		UCMD_OP_IXT = 6'h0F,
		UCMD_INVOP = 6'h3F
	} ucmdT;

	typedef enum logic [5:0] {
		IXS_NOP = 6'h00,
		IXS_MOVT = 6'h01,
		IXS_MOVNT = 6'h02
	} ixsT;

	typedef enum logic [5:0] {
		IXT_NOP = 6'h00,
		IXT_SLEEP = 6'h01,
		IXT_BREAK = 6'h02,
		IXT_CLRT = 6'h03,
		IXT_SETT = 6'h04,
		IXT_NOTT = 6'h05,
		IXT_CLRS = 6'h06,
		IXT_SETS = 6'h07,
		IXT_NOTS = 6'h08,
		IXT_RTE = 6'h09,
		IXT_TRAPA = 6'h0A,
		IXT_SYSE = 6'h0B
	} ixtT;

	// Run always, never, if T set, if T clear
	typedef enum logic [1:0] {
		CC_AL = 2'b00,
		CC_NV = 2'b01,
		CC_CT = 2'b10,
		CC_CF = 2'b11
	} condT;

	typedef struct packed {
		logic [1:0] dir; // 10 store, 01 load
		logic isUnsigned;
		logic [1:0] size;
	} memOpmT;

	parameter memOpmT MEM_OPM_READY = '0;

	typedef enum logic [1:0] {
		MEMOK_READY = 2'b00,
		MEMOK_OK = 2'b01,
		MEMOK_HOLD = 2'b10,
		MEMOK_FAULT = 2'b11
	} memOkT;

endpackage

`default_nettype wire

/* src/opGate.sv */
// Micro-op gating on condition code, SR.T and branch flush
`default_nettype none

module opGate (
	input wire logic [7:0] opUCmd,
	input wire logic opBraFlush,
	input wire logic srT,
	output exStagePkg::ucmdT gatedCmd,
	output logic [7:0] opUCmdOut
);

	exStagePkg::condT cond;
	exStagePkg::ucmdT rawCmd;
	logic opEnable;

	assign cond = exStagePkg::condT'(opUCmd[7:6]);
	assign rawCmd = exStagePkg::ucmdT'(opUCmd[5:0]);

	always_comb begin
		case (cond)
			exStagePkg::CC_AL: opEnable = 1'b1;
			exStagePkg::CC_CT: opEnable = srT;
			exStagePkg::CC_CF: opEnable = !srT;
			default: opEnable = 1'b0;
		endcase
		if (opBraFlush)
			opEnable = 1'b0;
	end

	always_comb begin
		if (opEnable)
			gatedCmd = rawCmd;
		else if ((rawCmd == exStagePkg::UCMD_BRA) && !opBraFlush)
			gatedCmd = exStagePkg::UCMD_BRA_NB; // Lets a predicted branch be undone
		else
			gatedCmd = exStagePkg::UCMD_NOP;
	end

	assign opUCmdOut = {exStagePkg::CC_AL, gatedCmd}; // Later stages see it as unconditional

endmodule

`default_nettype wire

/* src/addrGen.sv */
// Scaled base plus index address generator
`default_nettype none

`include "exStageMacros.svh"

module addrGen (
	input wire logic [`EX_ALEN-1:0] base,
	input wire logic [`EX_ALEN-1:0] index,
	input wire logic [1:0] scale,
	output logic [`EX_ALEN-1:0] aguAddr
);

	logic [`EX_ALEN-1:0] scaledIndex;

	// Scale follows the access size of 1 to 8 bytes
	always_comb begin
		case (scale)
			2'd0: scaledIndex = index;
			2'd1: scaledIndex = {index[`EX_ALEN-2:0], 1'b0};
			2'd2: scaledIndex = {index[`EX_ALEN-3:0], 2'b0};
			default: scaledIndex = {index[`EX_ALEN-4:0], 3'b0};
		endcase
	end

	assign aguAddr = base + scaledIndex; // Wraps at the address width

endmodule

`default_nettype wire

/* src/moveUnit.sv */
// GPR destination select for LEA, CR moves, immediate loads and MOVT/MOVNT
`default_nettype none

`include "exStageMacros.svh"

module moveUnit (
	input wire exStagePkg::ucmdT gatedCmd,
	input wire logic [7:0] opUIxt,
	input wire logic [`EX_GR_ID_W-1:0] regIdRm,
	input wire logic [`EX_XLEN-1:0] regValRs,
	input wire logic [`EX_XLEN-1:0] regValRt,
	input wire logic [`EX_XLEN-1:0] regValCRm,
	input wire logic [32:0] regValImm,
	input wire logic [`EX_ALEN-1:0] aguAddr,
	input wire logic srT,
	output logic [`EX_GR_ID_W-1:0] regIdRn1,
	output logic [`EX_XLEN-1:0] regValRn1
);

	always_comb begin
		regIdRn1 = `EX_GR_ZZR;
		regValRn1 = '0;
		case (gatedCmd)
			exStagePkg::UCMD_LEA_MR: begin
				regIdRn1 = regIdRm;
				regValRn1 = {{(`EX_XLEN-`EX_ALEN){1'b0}}, aguAddr};
			end
			exStagePkg::UCMD_MOV_CR: begin
				regIdRn1 = regIdRm;
				regValRn1 = regValCRm;
			end
			exStagePkg::UCMD_MOV_IR: begin
				regIdRn1 = regIdRm;
				case (opUIxt[3:0])
					4'h0: regValRn1 = {{31{regValImm[32]}}, regValImm}; // Sign-extended imm
					4'h1: regValRn1 = {regValRs[55:0], regValImm[7:0]};
					4'h2: regValRn1 = {regValRs[47:0], regValImm[15:0]};
					4'h3: regValRn1 = {regValRs[31:0], regValImm[31:0]};
					default: regValRn1 = regValRt; // Jumbo immediate already built
				endcase
			end
			exStagePkg::UCMD_OP_IXS: begin
				case (opUIxt[5:0])
					exStagePkg::IXS_MOVT: begin
						regIdRn1 = regIdRm;
						regValRn1 = {{(`EX_XLEN-1){1'b0}}, srT};
					end
					exStagePkg::IXS_MOVNT: begin
						regIdRn1 = regIdRm;
						regValRn1 = {{(`EX_XLEN-1){1'b0}}, !srT};
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/branchUnit.sv */
// Control register writes, PC redirect and link register update
`default_nettype none

`include "exStageMacros.svh"

module branchUnit (
	input wire exStagePkg::ucmdT gatedCmd,
	input wire logic opPreBra,
	input wire logic [`EX_GR_ID_W-1:0] regIdRm,
	input wire logic [`EX_XLEN-1:0] regValRs,
	input wire logic [`EX_ALEN-1:0] regValPc,
	input wire logic [`EX_ALEN-1:0] aguAddr,
	input wire logic [`EX_ALEN-1:0] regInLr,
	output logic [`EX_CR_ID_W-1:0] regIdCn1,
	output logic [`EX_XLEN-1:0] regValCn1,
	output logic [`EX_ALEN-1:0] regOutLr
);

	logic [`EX_ALEN-1:0] relTarget;
	logic [`EX_ALEN-1:0] braTarget;
	logic doBra;

	assign relTarget = {regValPc[47:32], aguAddr[31:0]}; // Relative branches stay in the 4GB region

	always_comb begin
		doBra = 1'b0;
		braTarget = relTarget;
		regOutLr = regInLr;
		case (gatedCmd)
			exStagePkg::UCMD_BRA: doBra = !opPreBra; // Already taken by fetch if predicted
			exStagePkg::UCMD_BSR: begin
				doBra = !opPreBra;
				regOutLr = regValPc;
			end
			exStagePkg::UCMD_BRA_NB: begin
				doBra = opPreBra; // Mispredicted so return to the fall-through PC
				braTarget = regValPc;
			end
			exStagePkg::UCMD_JMP: begin
				doBra = 1'b1;
				braTarget = regValRs[`EX_ALEN-1:0];
			end
			exStagePkg::UCMD_JSR: begin
				doBra = 1'b1;
				braTarget = regValRs[`EX_ALEN-1:0];
				regOutLr = regValPc;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		regIdCn1 = `EX_CR_ZZR;
		regValCn1 = '0;
		if (gatedCmd == exStagePkg::UCMD_MOV_RC) begin
			regIdCn1 = regIdRm[`EX_CR_ID_W-1:0];
			regValCn1 = regValRs;
		end
		if (doBra) begin
			regIdCn1 = `EX_CR_PC;
			regValCn1 = {{(`EX_XLEN-`EX_ALEN){1'b0}}, braTarget};
		end
	end

endmodule

`default_nettype wire

/* src/statusUnit.sv */
// SR T and S bit updates and trap code generation
`default_nettype none

`include "exStageMacros.svh"

module statusUnit (
	input wire exStagePkg::ucmdT gatedCmd,
	input wire logic [7:0] opUIxt,
	input wire logic [`EX_GR_ID_W-1:0] regIdRm,
	input wire logic [`EX_XLEN-1:0] regInSr,
	input wire logic [`EX_XLEN-1:0] regInDlr,
	output logic [`EX_XLEN-1:0] regOutSr,
	output logic [15:0] exTrapExc
);

	logic isIxt;

	assign isIxt = (gatedCmd == exStagePkg::UCMD_OP_IXT);

	// Bit 0 is T, bit 1 is S
	always_comb begin
		regOutSr = regInSr;
		if (isIxt) begin
			case (opUIxt[5:0])
				exStagePkg::IXT_CLRT: regOutSr[0] = 1'b0;
				exStagePkg::IXT_SETT: regOutSr[0] = 1'b1;
				exStagePkg::IXT_NOTT: regOutSr[0] = !regInSr[0];
				exStagePkg::IXT_CLRS: regOutSr[1] = 1'b0;
				exStagePkg::IXT_SETS: regOutSr[1] = 1'b1;
				exStagePkg::IXT_NOTS: regOutSr[1] = !regInSr[1];
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		exTrapExc = '0;
		if (isIxt) begin
			case (opUIxt[5:0])
				exStagePkg::IXT_RTE: exTrapExc = `EX_TRAP_RTE;
				exStagePkg::IXT_TRAPA: begin
					exTrapExc = {`EX_TRAP_TRAPA_HI, regIdRm[3:0]}; // Vector from the Rm field
				end
				exStagePkg::IXT_SYSE: begin
					exTrapExc = {`EX_TRAP_SYSE_HI, regInDlr[11:0]}; // Syscall number in DLR
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/memRequest.sv */
// Load and store request issue
`default_nettype none

`include "exStageMacros.svh"

module memRequest (
	input wire exStagePkg::ucmdT gatedCmd,
	input wire logic [7:0] opUIxt,
	input wire logic [`EX_ALEN-1:0] aguAddr,
	input wire logic [`EX_XLEN-1:0] regValRm,
	output logic [`EX_ALEN-1:0] memAddr,
	output exStagePkg::memOpmT memOpm,
	output logic [`EX_XLEN-1:0] memDataOut,
	output logic memActive
);

	logic isStore;
	logic isLoad;

	assign isStore = (gatedCmd == exStagePkg::UCMD_MOV_RM);
	assign isLoad = (gatedCmd == exStagePkg::UCMD_MOV_MR);
	assign memActive = isStore || isLoad;

	always_comb begin
		memOpm = exStagePkg::MEM_OPM_READY;
		if (memActive) begin
			memOpm.dir = isStore ? 2'b10 : 2'b01;
			memOpm.isUnsigned = opUIxt[2];
			memOpm.size = opUIxt[5:4]; // Same field scales the index
		end
	end

	assign memAddr = aguAddr;
	assign memDataOut = regValRm; // Only sampled on a store

endmodule

`default_nettype wire

/* src/hazardControl.sv */
// Stall and held destination flags
`default_nettype none

`include "exStageMacros.svh"

module hazardControl (
	input wire exStagePkg::ucmdT gatedCmd,
	input wire logic [7:0] opUIxt,
	input wire logic [`EX_GR_ID_W-1:0] regIdRm,
	input wire logic [`EX_XLEN-1:0] regInExc,
	input wire logic memActive,
	input wire exStagePkg::memOkT memDataOK,
	output logic [1:0] exHold,
	output logic [`EX_GR_ID_W-1:0] heldIdRn1
);

	logic decodeStall;
	logic memStall;

	always_comb begin
		decodeStall = 1'b0;
		heldIdRn1 = `EX_GR_ZZR;
		case (gatedCmd)
			exStagePkg::UCMD_NOP, exStagePkg::UCMD_MOV_RM, exStagePkg::UCMD_LEA_MR,
			exStagePkg::UCMD_MOV_RC, exStagePkg::UCMD_MOV_CR, exStagePkg::UCMD_MOV_IR,
			exStagePkg::UCMD_BRA, exStagePkg::UCMD_BRA_NB, exStagePkg::UCMD_BSR,
			exStagePkg::UCMD_JMP, exStagePkg::UCMD_JSR: begin
			end
			exStagePkg::UCMD_ALU3, exStagePkg::UCMD_MUL3,
			exStagePkg::UCMD_MOV_MR: heldIdRn1 = regIdRm; // Result lands in a later stage
			exStagePkg::UCMD_OP_IXS: begin
				decodeStall = (opUIxt[5:0] > exStagePkg::IXS_MOVNT);
			end
			exStagePkg::UCMD_OP_IXT: begin
				if (opUIxt[5:0] == exStagePkg::IXT_BREAK)
					decodeStall = !regInExc[15]; // Debugger may let it through
				else
					decodeStall = (opUIxt[5:0] > exStagePkg::IXT_SYSE);
			end
			default: decodeStall = 1'b1; // INVOP and unknown opcodes
		endcase
	end

	assign memStall = memActive && (memDataOK == exStagePkg::MEMOK_HOLD);

	assign exHold = {heldIdRn1 != `EX_GR_ZZR, decodeStall || memStall};

endmodule

`default_nettype wire

/* src/exStage.sv */
// First execute stage top level
`default_nettype none

`include "exStageMacros.svh"

module exStage (
	input wire logic [7:0] opUCmd,
	input wire logic [7:0] opUIxt,
	input wire logic [`EX_GR_ID_W-1:0] regIdRs,
	input wire logic [`EX_GR_ID_W-1:0] regIdRt,
	input wire logic [`EX_GR_ID_W-1:0] regIdRm,
	input wire logic [`EX_XLEN-1:0] regValRs,
	input wire logic [`EX_XLEN-1:0] regValRt,
	input wire logic [`EX_XLEN-1:0] regValRm,
	input wire logic [`EX_XLEN-1:0] regValCRm,
	input wire logic [`EX_ALEN-1:0] regValPc,
	input wire logic [32:0] regValImm,
	input wire logic opBraFlush,
	input wire logic opPreBra,
	input wire logic [`EX_XLEN-1:0] regInSr,
	input wire logic [`EX_ALEN-1:0] regInLr,
	input wire logic [`EX_XLEN-1:0] regInDlr,
	input wire logic [`EX_XLEN-1:0] regInExc,
	input wire exStagePkg::memOkT memDataOK,
	output logic [7:0] opUCmdOut,
	output logic [1:0] exHold,
	output logic [15:0] exTrapExc,
	output logic [`EX_GR_ID_W-1:0] regIdRn1,
	output logic [`EX_XLEN-1:0] regValRn1,
	output logic [`EX_CR_ID_W-1:0] regIdCn1,
	output logic [`EX_XLEN-1:0] regValCn1,
	output logic [`EX_GR_ID_W-1:0] heldIdRn1,
	output logic [`EX_XLEN-1:0] regOutSr,
	output logic [`EX_ALEN-1:0] regOutLr,
	output logic [`EX_ALEN-1:0] memAddr,
	output exStagePkg::memOpmT memOpm,
	output logic [`EX_XLEN-1:0] memDataOut
);

	exStagePkg::ucmdT gatedCmd;
	logic [`EX_ALEN-1:0] aguAddr;
	logic memActive;

	opGate iOpGate (.opUCmd(opUCmd), .opBraFlush(opBraFlush), .srT(regInSr[0]),
		.gatedCmd(gatedCmd), .opUCmdOut(opUCmdOut));

	addrGen iAddrGen (.base(regValRs[`EX_ALEN-1:0]), .index(regValRt[`EX_ALEN-1:0]),
		.scale(opUIxt[5:4]), .aguAddr(aguAddr));

	moveUnit iMoveUnit (.gatedCmd(gatedCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValCRm(regValCRm),
		.regValImm(regValImm), .aguAddr(aguAddr), .srT(regInSr[0]),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1));

	branchUnit iBranchUnit (.gatedCmd(gatedCmd), .opPreBra(opPreBra), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValPc(regValPc), .aguAddr(aguAddr), .regInLr(regInLr),
		.regIdCn1(regIdCn1), .regValCn1(regValCn1), .regOutLr(regOutLr));

	statusUnit iStatusUnit (.gatedCmd(gatedCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regInSr(regInSr), .regInDlr(regInDlr), .regOutSr(regOutSr),
		.exTrapExc(exTrapExc));

	memRequest iMemRequest (.gatedCmd(gatedCmd), .opUIxt(opUIxt), .aguAddr(aguAddr),
		.regValRm(regValRm), .memAddr(memAddr), .memOpm(memOpm),
		.memDataOut(memDataOut), .memActive(memActive));

	hazardControl iHazardControl (.gatedCmd(gatedCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regInExc(regInExc), .memActive(memActive), .memDataOK(memDataOK),
		.exHold(exHold), .heldIdRn1(heldIdRn1));

endmodule

`default_nettype wire

/* dv/exStageTb.sv */
// Execute stage testbench driving random micro-ops and checking them against a reference model
`default_nettype none

`include "exStageMacros.svh"

module exStageTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TESTS = 6;
	localparam int VECTORS = 400;
	localparam int CYCLE_LIMIT = TESTS * VECTORS + 200; // Reset plus some slack

	logic clock = 1'b0;
	logic reset;
	logic [63:0] rngState = 64'd86817;
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testErrors;
	string testName;
	string testNames [TESTS] = '{"gating", "regWrites", "memory", "branches", "status", "hazards"};

	logic [7:0] opUCmd;
	logic [7:0] opUIxt;
	logic [`EX_GR_ID_W-1:0] regIdRs;
	logic [`EX_GR_ID_W-1:0] regIdRt;
	logic [`EX_GR_ID_W-1:0] regIdRm;
	logic [`EX_XLEN-1:0] regValRs;
	logic [`EX_XLEN-1:0] regValRt;
	logic [`EX_XLEN-1:0] regValRm;
	logic [`EX_XLEN-1:0] regValCRm;
	logic [`EX_ALEN-1:0] regValPc;
	logic [32:0] regValImm;
	logic opBraFlush;
	logic opPreBra;
	logic [`EX_XLEN-1:0] regInSr;
	logic [`EX_ALEN-1:0] regInLr;
	logic [`EX_XLEN-1:0] regInDlr;
	logic [`EX_XLEN-1:0] regInExc;
	exStagePkg::memOkT memDataOK;

	logic [7:0] opUCmdOut;
	logic [1:0] exHold;
	logic [15:0] exTrapExc;
	logic [`EX_GR_ID_W-1:0] regIdRn1;
	logic [`EX_XLEN-1:0] regValRn1;
	logic [`EX_CR_ID_W-1:0] regIdCn1;
	logic [`EX_XLEN-1:0] regValCn1;
	logic [`EX_GR_ID_W-1:0] heldIdRn1;
	logic [`EX_XLEN-1:0] regOutSr;
	logic [`EX_ALEN-1:0] regOutLr;
	logic [`EX_ALEN-1:0] memAddr;
	exStagePkg::memOpmT memOpm;
	logic [`EX_XLEN-1:0] memDataOut;

	logic [7:0] expUCmdOut;
	logic [1:0] expHold;
	logic [15:0] expTrap;
	logic [`EX_GR_ID_W-1:0] expIdRn1;
	logic [`EX_XLEN-1:0] expValRn1;
	logic [`EX_CR_ID_W-1:0] expIdCn1;
	logic [`EX_XLEN-1:0] expValCn1;
	logic [`EX_GR_ID_W-1:0] expHeldId;
	logic [`EX_XLEN-1:0] expSr;
	logic [`EX_ALEN-1:0] expLr;
	logic [`EX_ALEN-1:0] expMemAddr;
	logic [4:0] expOpm;
	logic [`EX_XLEN-1:0] expMemData;

	exStage i_dut (.*);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [63:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 7);
		rngState = rngState ^ (rngState << 17);
		return rngState;
	endfunction

	function automatic int randBelow(input int n);
		logic [63:0] r;
		r = nextRand();
		return int'(r % 64'(n));
	endfunction

	// Opcode mix for each test
	function automatic logic [5:0] pickOp(input int test);
		int k;
		k = randBelow(6);
		case (test)
			0: case (k)
				0, 1: return exStagePkg::UCMD_BRA;
				2: return exStagePkg::UCMD_MOV_IR;
				3: return exStagePkg::UCMD_LEA_MR;
				4: return exStagePkg::UCMD_ALU3;
				default: return exStagePkg::UCMD_MOV_RM;
			endcase
			1: case (k)
				0: return exStagePkg::UCMD_LEA_MR;
				1: return exStagePkg::UCMD_MOV_CR;
				2, 3: return exStagePkg::UCMD_MOV_IR;
				default: return exStagePkg::UCMD_OP_IXS;
			endcase
			2: case (k)
				0, 1: return exStagePkg::UCMD_MOV_RM;
				2, 3: return exStagePkg::UCMD_MOV_MR;
				4: return exStagePkg::UCMD_LEA_MR;
				default: return exStagePkg::UCMD_NOP;
			endcase
			3: case (k)
				0: return exStagePkg::UCMD_BRA;
				1: return exStagePkg::UCMD_BRA_NB;
				2: return exStagePkg::UCMD_BSR;
				3: return exStagePkg::UCMD_JMP;
				4: return exStagePkg::UCMD_JSR;
				default: return exStagePkg::UCMD_MOV_RC;
			endcase
			4: return exStagePkg::UCMD_OP_IXT;
			default: case (k)
				0: return exStagePkg::UCMD_ALU3;
				1: return exStagePkg::UCMD_MUL3;
				2: return exStagePkg::UCMD_MOV_MR;
				3: return exStagePkg::UCMD_INVOP;
				4: return 6'(randBelow(64)); // Any opcode but mostly unknown ones
				default: return exStagePkg::UCMD_OP_IXS;
			endcase
		endcase
	endfunction

	task automatic applyVector(input int test);
		logic [1:0] cc;
		logic [5:0] op;
		logic [7:0] ixt;
		logic [63:0] r;
		r = nextRand();
		ixt = r[7:0];
		cc = (test == 0 || randBelow(4) == 0) ? 2'(randBelow(4)) : exStagePkg::CC_AL;
		op = pickOp(test);
		if (op == exStagePkg::UCMD_MOV_IR)
			ixt[3:0] = 4'(randBelow(6)); // Shift forms and a few Rt forms
		if (op == exStagePkg::UCMD_OP_IXS)
			ixt[5:0] = 6'(randBelow(test == 5 ? 8 : 4));
		if (op == exStagePkg::UCMD_OP_IXT)
			ixt[5:0] = 6'(randBelow(14)); // Includes two unknown sub-ops
		opUCmd <= {cc, op};
		opUIxt <= ixt;
		opBraFlush <= (randBelow(test == 0 ? 2 : 8) == 0);
		opPreBra <= r[8];
		regIdRs <= r[21:16];
		regIdRt <= r[29:24];
		regIdRm <= r[37:32];
		memDataOK <= exStagePkg::memOkT'(r[41:40]);
		regValRs <= nextRand();
		regValRt <= nextRand();
		regValRm <= nextRand();
		regValCRm <= nextRand();
		regValPc <= 48'(nextRand());
		regValImm <= 33'(nextRand());
		regInSr <= nextRand();
		regInLr <= 48'(nextRand());
		regInDlr <= nextRand();
		regInExc <= nextRand();
	endtask

	// Reference model of the stage
	task automatic computeExpected();
		logic [5:0] op;
		logic [5:0] g;
		logic [5:0] sub;
		logic [1:0] cc;
		logic en;
		logic stall;
		logic memOn;
		logic [47:0] agu;
		op = opUCmd[5:0];
		cc = opUCmd[7:6];
		sub = opUIxt[5:0];
		en = (cc == exStagePkg::CC_AL) || (cc == exStagePkg::CC_CT && regInSr[0]) ||
			(cc == exStagePkg::CC_CF && !regInSr[0]);
		if (opBraFlush)
			en = 1'b0;
		if (en)
			g = op;
		else if (op == exStagePkg::UCMD_BRA && !opBraFlush)
			g = exStagePkg::UCMD_BRA_NB;
		else
			g = exStagePkg::UCMD_NOP;
		agu = regValRs[47:0] + (regValRt[47:0] << opUIxt[5:4]);
		expUCmdOut = {2'b00, g};
		expIdRn1 = `EX_GR_ZZR;
		expValRn1 = '0;
		expIdCn1 = `EX_CR_ZZR;
		expValCn1 = '0;
		expHeldId = `EX_GR_ZZR;
		expSr = regInSr;
		expLr = regInLr;
		expTrap = '0;
		expOpm = '0;
		expMemAddr = agu;
		expMemData = regValRm;
		stall = 1'b0;
		memOn = 1'b0;
		case (g)
			exStagePkg::UCMD_NOP: begin
			end
			exStagePkg::UCMD_LEA_MR: begin
				expIdRn1 = regIdRm;
				expValRn1 = {16'h0, agu};
			end
			exStagePkg::UCMD_MOV_CR: begin
				expIdRn1 = regIdRm;
				expValRn1 = regValCRm;
			end
			exStagePkg::UCMD_MOV_IR: begin
				expIdRn1 = regIdRm;
				case (opUIxt[3:0])
					4'h0: expValRn1 = {{31{regValImm[32]}}, regValImm};
					4'h1: expValRn1 = (regValRs << 8) | {56'h0, regValImm[7:0]};
					4'h2: expValRn1 = (regValRs << 16) | {48'h0, regValImm[15:0]};
					4'h3: expValRn1 = (regValRs << 32) | {32'h0, regValImm[31:0]};
					default: expValRn1 = regValRt;
				endcase
			end
			exStagePkg::UCMD_OP_IXS: begin
				if (sub == 6'd1 || sub == 6'd2) begin
					expIdRn1 = regIdRm;
					expValRn1 = {63'h0, regInSr[0] ^ (sub == 6'd2)}; // MOVNT inverts T
				end else if (sub != 6'd0)
					stall = 1'b1;
			end
			exStagePkg::UCMD_MOV_RC: begin
				expIdCn1 = regIdRm[4:0];
				expValCn1 = regValRs;
			end
			exStagePkg::UCMD_BRA, exStagePkg::UCMD_BSR: begin
				if (!opPreBra) begin
					expIdCn1 = `EX_CR_PC;
					expValCn1 = {16'h0, regValPc[47:32], agu[31:0]};
				end
				if (g == exStagePkg::UCMD_BSR)
					expLr = regValPc;
			end
			exStagePkg::UCMD_BRA_NB: begin
				if (opPreBra) begin
					expIdCn1 = `EX_CR_PC;
					expValCn1 = {16'h0, regValPc};
				end
			end
			exStagePkg::UCMD_JMP, exStagePkg::UCMD_JSR: begin
				expIdCn1 = `EX_CR_PC;
				expValCn1 = {16'h0, regValRs[47:0]};
				if (g == exStagePkg::UCMD_JSR)
					expLr = regValPc;
			end
			exStagePkg::UCMD_MOV_RM: begin
				memOn = 1'b1;
				expOpm = {2'b10, opUIxt[2], opUIxt[5:4]};
			end
			exStagePkg::UCMD_MOV_MR: begin
				memOn = 1'b1;
				expOpm = {2'b01, opUIxt[2], opUIxt[5:4]};
				expHeldId = regIdRm;
			end
			exStagePkg::UCMD_ALU3, exStagePkg::UCMD_MUL3: expHeldId = regIdRm;
			exStagePkg::UCMD_OP_IXT: begin
				case (sub)
					exStagePkg::IXT_NOP, exStagePkg::IXT_SLEEP: begin
					end
					exStagePkg::IXT_BREAK: stall = !regInExc[15];
					exStagePkg::IXT_CLRT: expSr[0] = 1'b0;
					exStagePkg::IXT_SETT: expSr[0] = 1'b1;
					exStagePkg::IXT_NOTT: expSr[0] = !regInSr[0];
					exStagePkg::IXT_CLRS: expSr[1] = 1'b0;
					exStagePkg::IXT_SETS: expSr[1] = 1'b1;
					exStagePkg::IXT_NOTS: expSr[1] = !regInSr[1];
					exStagePkg::IXT_RTE: expTrap = 16'hFF00;
					exStagePkg::IXT_TRAPA: expTrap = {12'hC08, regIdRm[3:0]};
					exStagePkg::IXT_SYSE: expTrap = {4'hE, regInDlr[11:0]};
					default: stall = 1'b1;
				endcase
			end
			default: stall = 1'b1; // INVOP and unknown opcodes
		endcase
		expHold = {expHeldId != `EX_GR_ZZR,
			stall || (memOn && memDataOK == exStagePkg::MEMOK_HOLD)};
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("ERROR %s %s: expected %h, actual %h", testName, name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkOutputs();
		checkValue("opUCmdOut", 64'(expUCmdOut), 64'(opUCmdOut));
		checkValue("exHold", 64'(expHold), 64'(exHold));
		checkValue("exTrapExc", 64'(expTrap), 64'(exTrapExc));
		checkValue("regIdRn1", 64'(expIdRn1), 64'(regIdRn1));
		checkValue("regValRn1", expValRn1, regValRn1);
		checkValue("regIdCn1", 64'(expIdCn1), 64'(regIdCn1));
		checkValue("regValCn1", expValCn1, regValCn1);
		checkValue("heldIdRn1", 64'(expHeldId), 64'(heldIdRn1));
		checkValue("regOutSr", expSr, regOutSr);
		checkValue("regOutLr", 64'(expLr), 64'(regOutLr));
		checkValue("memAddr", 64'(expMemAddr), 64'(memAddr));
		checkValue("memOpm", 64'(expOpm), 64'(memOpm));
		checkValue("memDataOut", expMemData, memDataOut);
	endtask

	initial begin
		reset = 1'b1;
		opUCmd = '0;
		opUIxt = '0;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValCRm = '0;
		regValPc = '0;
		regValImm = '0;
		opBraFlush = 1'b0;
		opPreBra = 1'b0;
		regInSr = '0;
		regInLr = '0;
		regInDlr = '0;
		regInExc = '0;
		memDataOK = exStagePkg::MEMOK_READY;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		for (int t = 0; t < TESTS; t++) begin
			testName = testNames[t];
			testErrors = 0;
			for (int v = 0; v < VECTORS; v++) begin
				@(posedge clock);
				applyVector(t);
				@(negedge clock); // Outputs settled half a cycle after the inputs
				computeExpected();
				checkOutputs();
			end
			$display("%s: %0d vectors, %0d errors", testName, VECTORS, testErrors);
		end
		$display("Totals: %0d tests, %0d checks, %0d errors", TESTS, checkCount, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/exStagePkg.sv
src/opGate.sv
src/addrGen.sv
src/moveUnit.sv
src/branchUnit.sv
src/statusUnit.sv
src/memRequest.sv
src/hazardControl.sv
src/exStage.sv
dv/exStageTb.sv

/* build.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 -f src.f --top-module exStageTb -o exStageSim > build.log 2>&1 &&
	./obj_dir/exStageSim > sim.log 2>&1 ||
	echo "Build or simulation returned an error, see build.log and sim.log"
if grep -q "All checks passed" sim.log 2>/dev/null; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
